//--- common/mrd_cfg_pkg.sv
`default_nettype none

package mrd_cfg_pkg;

	// banks of the radix-7 reorder memory
	localparam int NUM_BANKS = 7;
	localparam int BANK_W = 3;

	// rows per bank, 2044 / 7 fits comfortably
	localparam int ADDR_W = 9;
	localparam int BANK_DEPTH = 1 << ADDR_W;

	// frame length and sample counters
	localparam int LEN_W = 12;

	// one real or imaginary part
	localparam int DATA_W = 16;

	// sink cycles before the frame is abandoned
	localparam int STALL_LIMIT = 2047;

	// write pipeline depth seen from the FSM
	localparam int DRAIN_CYCLES = 2;
	localparam int DRAIN_W = $clog2(DRAIN_CYCLES + 1);

endpackage

`default_nettype wire

//--- common/mrd_types_pkg.sv
`default_nettype none

package mrd_types_pkg;

	import mrd_cfg_pkg::*;

	typedef struct packed {
		logic signed [DATA_W-1:0] re;
		logic signed [DATA_W-1:0] im;
	} sample_t;

	// encodings kept from the six-state version
	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		SINK       = 3'd1,
		WAIT_TO_RD = 3'd2,
		SOURCE     = 3'd5
	} mrd_state_t;

	// bank 0 sits on the msb
	typedef logic [NUM_BANKS-1:0] bank_wren_t;

endpackage

`default_nettype wire

//--- logic/mrd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_ctrl
	import mrd_cfg_pkg::*, mrd_types_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  logic [LEN_W-1:0] frame_len,
	input  logic             stall,
	input  logic             src_done,
	output mrd_state_t       state,
	output logic [LEN_W-1:0] len_q,
	output logic             src_start,
	output logic             busy,
	output logic             timeout_err
);

	logic [DRAIN_W-1:0] drain_cnt;

	assign busy = (state != IDLE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= IDLE;
			len_q       <= '0;
			drain_cnt   <= '0;
			src_start   <= 1'b0;
			timeout_err <= 1'b0;
		end else begin
			src_start <= 1'b0;
			case (state)
			IDLE: begin
				// a timed-out buffer takes no more frames until reset
				if (in_valid && !timeout_err) begin
					state <= SINK;
					len_q <= frame_len;
				end
			end
			SINK: begin
				if (stall) begin
					timeout_err <= 1'b1;
					state       <= IDLE;
				end else if (!in_valid) begin
					state     <= WAIT_TO_RD;
					drain_cnt <= '0;
				end
			end
			WAIT_TO_RD: begin
				// let the last writes land before reading
				if (drain_cnt == DRAIN_W'(DRAIN_CYCLES - 1)) begin
					state     <= SOURCE;
					src_start <= 1'b1;
				end else begin
					drain_cnt <= drain_cnt + DRAIN_W'(1);
				end
			end
			SOURCE: begin
				if (src_done)
					state <= IDLE;
			end
			default: begin
				state <= IDLE;
			end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- sink/mrd_sink.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_sink
	import mrd_cfg_pkg::*, mrd_types_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  mrd_state_t        state,
	input  logic              in_valid,
	input  sample_t           in_data,
	input  logic [LEN_W-1:0]  len_q,
	output logic [ADDR_W-1:0] wr_addr,
	output bank_wren_t        wr_en,
	output sample_t           wr_data,
	output logic              sink_3_4,
	output logic              stall
);

	logic [BANK_W-1:0] idx_pre;
	logic [ADDR_W-1:0] row_pre;
	logic [BANK_W-1:0] idx_d1;
	logic [BANK_W-1:0] idx_d2;
	logic [ADDR_W-1:0] row_d1;
	logic              vld_d1;
	logic              vld_d2;
	sample_t           data_d1;
	logic [LEN_W-1:0]  cnt_sink;
	logic [LEN_W-1:0]  cnt_stall;
	logic [LEN_W-1:0]  three_q;

	// round-robin over the banks, next row after bank 6
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idx_pre <= '0;
			row_pre <= '0;
		end else if (in_valid) begin
			if (idx_pre == BANK_W'(NUM_BANKS - 1)) begin
				idx_pre <= '0;
				row_pre <= row_pre + ADDR_W'(1);
			end else begin
				idx_pre <= idx_pre + BANK_W'(1);
			end
		end else begin
			idx_pre <= '0;
			row_pre <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_d1 <= 1'b0;
			vld_d2 <= 1'b0;
		end else begin
			vld_d1 <= in_valid;
			vld_d2 <= vld_d1;
		end
	end

	// two stages, write lands two edges after acceptance
	always_ff @(posedge clk) begin
		idx_d1  <= idx_pre;
		row_d1  <= row_pre;
		data_d1 <= in_data;
		idx_d2  <= idx_d1;
		wr_addr <= row_d1;
		wr_data <= data_d1;
	end

	always_comb begin
		wr_en = '0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (vld_d2 && idx_d2 == BANK_W'(b))
				wr_en[NUM_BANKS-1-b] = 1'b1;
		end
	end

	// len/4 + len/2 - 1 samples
	assign three_q = LEN_W'(len_q[LEN_W-1:2]) + LEN_W'(len_q[LEN_W-1:1]) - LEN_W'(1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt_sink  <= '0;
			cnt_stall <= '0;
			sink_3_4  <= 1'b0;
			stall     <= 1'b0;
		end else begin
			cnt_sink  <= in_valid ? cnt_sink + LEN_W'(1) : '0;
			sink_3_4  <= (cnt_sink != '0) && (cnt_sink == three_q);
			cnt_stall <= (state == SINK) ? cnt_stall + LEN_W'(1) : '0;
			stall     <= (cnt_stall == LEN_W'(STALL_LIMIT));
		end
	end

endmodule

`default_nettype wire

//--- logic/mrd_bank_array.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_bank_array
	import mrd_cfg_pkg::*, mrd_types_pkg::*;
(
	input  logic              clk,
	input  logic [ADDR_W-1:0] wr_addr,
	input  bank_wren_t        wr_en,
	input  sample_t           wr_data,
	input  logic [BANK_W-1:0] rd_bank,
	input  logic [ADDR_W-1:0] rd_addr,
	output sample_t           rd_data
);

	sample_t           bank_rd [NUM_BANKS];
	logic [BANK_W-1:0] rd_bank_q;

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		sample_t mem [BANK_DEPTH];
		sample_t rd_q;

		// every bank reads, the select below picks one
		always_ff @(posedge clk) begin
			if (wr_en[NUM_BANKS-1-b])
				mem[wr_addr] <= wr_data;
			rd_q <= mem[rd_addr];
		end

		assign bank_rd[b] = rd_q;
	end

	always_ff @(posedge clk) begin
		rd_bank_q <= rd_bank;
	end

	always_comb begin
		if (rd_bank_q < BANK_W'(NUM_BANKS))
			rd_data = bank_rd[rd_bank_q];
		else
			rd_data = '0;
	end

endmodule

`default_nettype wire

//--- source/mrd_source.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_source
	import mrd_cfg_pkg::*, mrd_types_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              src_start,
	input  logic [LEN_W-1:0]  len_q,
	output logic [BANK_W-1:0] rd_bank,
	output logic [ADDR_W-1:0] rd_addr,
	input  sample_t           rd_data,
	output logic              src_done,
	output logic              out_valid,
	output sample_t           out_data,
	output logic              out_last
);

	logic [ADDR_W-1:0] rows_q;
	logic [ADDR_W-1:0] row_end;
	logic              active;
	logic              row_wrap;
	logic              is_last;
	logic              vld_d1;
	logic              last_d1;

	assign row_end  = rows_q - ADDR_W'(1);
	assign row_wrap = (rd_addr == row_end);
	assign is_last  = row_wrap && (rd_bank == BANK_W'(NUM_BANKS - 1));

	// goes out with the final read
	assign src_done = active && is_last;

	// R = frame_len / 7, taken once per frame
	always_ff @(posedge clk) begin
		if (src_start)
			rows_q <= ADDR_W'(len_q / LEN_W'(NUM_BANKS));
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active  <= 1'b0;
			rd_bank <= '0;
			rd_addr <= '0;
		end else if (src_start) begin
			active  <= 1'b1;
			rd_bank <= '0;
			rd_addr <= '0;
		end else if (active) begin
			if (is_last) begin
				active <= 1'b0;
			end else if (row_wrap) begin
				rd_addr <= '0;
				rd_bank <= rd_bank + BANK_W'(1);
			end else begin
				rd_addr <= rd_addr + ADDR_W'(1);
			end
		end
	end

	// one stage for the RAM, one for the output register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_d1    <= 1'b0;
			last_d1   <= 1'b0;
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end else begin
			vld_d1    <= active;
			last_d1   <= src_done;
			out_valid <= vld_d1;
			out_last  <= last_d1;
		end
	end

	always_ff @(posedge clk) begin
		out_data <= rd_data;
	end

endmodule

`default_nettype wire

//--- logic/mrd_reorder_top.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_reorder_top
	import mrd_cfg_pkg::*, mrd_types_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  sample_t          in_data,
	input  logic [LEN_W-1:0] frame_len,
	output logic             out_valid,
	output sample_t          out_data,
	output logic             out_last,
	output logic             busy,
	output logic             sink_3_4,
	output logic             timeout_err
);

	mrd_state_t        state;
	logic [LEN_W-1:0]  len_q;
	logic              src_start;
	logic              src_done;
	logic              stall;
	logic [ADDR_W-1:0] wr_addr;
	bank_wren_t        wr_en;
	sample_t           wr_data;
	logic [BANK_W-1:0] rd_bank;
	logic [ADDR_W-1:0] rd_addr;
	sample_t           rd_data;

	mrd_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.frame_len   (frame_len),
		.stall       (stall),
		.src_done    (src_done),
		.state       (state),
		.len_q       (len_q),
		.src_start   (src_start),
		.busy        (busy),
		.timeout_err (timeout_err)
	);

	mrd_sink u_sink (
		.clk      (clk),
		.rst_n    (rst_n),
		.state    (state),
		.in_valid (in_valid),
		.in_data  (in_data),
		.len_q    (len_q),
		.wr_addr  (wr_addr),
		.wr_en    (wr_en),
		.wr_data  (wr_data),
		.sink_3_4 (sink_3_4),
		.stall    (stall)
	);

	mrd_bank_array u_banks (
		.clk     (clk),
		.wr_addr (wr_addr),
		.wr_en   (wr_en),
		.wr_data (wr_data),
		.rd_bank (rd_bank),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	mrd_source u_source (
		.clk       (clk),
		.rst_n     (rst_n),
		.src_start (src_start),
		.len_q     (len_q),
		.rd_bank   (rd_bank),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.src_done  (src_done),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_last  (out_last)
	);

endmodule

`default_nettype wire

//--- tb/mrd_reorder_props.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_reorder_props (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic busy,
	input logic sink_3_4,
	input logic out_valid,
	input logic out_last,
	input logic timeout_err
);

	logic pulse_bad = 1'b0;
	logic last_bad = 1'b0;
	logic valid_bad = 1'b0;
	logic err_bad = 1'b0;
	logic any_fail;

	assign any_fail = pulse_bad | last_bad | valid_bad | err_bad;

	// three-quarter mark is a single-cycle pulse
	a_pulse_one: assert property (@(posedge clk) disable iff (!rst_n)
		sink_3_4 |=> !sink_3_4)
	else begin
		pulse_bad = 1'b1;
		$error("sink_3_4 stayed high for more than one cycle");
	end

	a_last_valid: assert property (@(posedge clk) disable iff (!rst_n)
		out_last |-> out_valid)
	else begin
		last_bad = 1'b1;
		$error("out_last seen without out_valid");
	end

	// a frame only starts from idle
	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(in_valid) |-> !busy)
	else begin
		valid_bad = 1'b1;
		$error("in_valid raised while the buffer was busy");
	end

	a_err_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		timeout_err |=> timeout_err)
	else begin
		err_bad = 1'b1;
		$error("timeout_err dropped outside reset");
	end

endmodule

bind mrd_reorder_top mrd_reorder_props u_props (
	.clk         (clk),
	.rst_n       (rst_n),
	.in_valid    (in_valid),
	.busy        (busy),
	.sink_3_4    (sink_3_4),
	.out_valid   (out_valid),
	.out_last    (out_last),
	.timeout_err (timeout_err)
);

`default_nettype wire

//--- tb/mrd_reorder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_reorder_tb
	import mrd_cfg_pkg::*, mrd_types_pkg::*;
();

	localparam int CLK_HALF = 10;
	localparam int NUM_FRAMES = 6;
	localparam int FRAME_LENS [NUM_FRAMES] = '{7, 63, 2044, 14, 63, 21};
	localparam int STALL_RUN = 2100;
	localparam int STALL_LEN = 63;

	// each frame streams in and then out, plus the stall run
	function automatic int cycle_limit();
		int total;
		total = STALL_RUN + 300;
		for (int i = 0; i < NUM_FRAMES; i++)
			total += 2 * FRAME_LENS[i] + 20;
		return total;
	endfunction

	localparam int MAX_CYCLES = cycle_limit();

	logic             clk;
	logic             rst_n;
	logic             in_valid;
	sample_t          in_data;
	logic [LEN_W-1:0] frame_len;
	logic             out_valid;
	sample_t          out_data;
	logic             out_last;
	logic             busy;
	logic             sink_3_4;
	logic             timeout_err;

	sample_t exp_q [$];
	logic    last_q [$];
	int      cur_len = 0;
	int      run_cnt = 0;
	logic    due_d1 = 1'b0;
	logic    due_d2 = 1'b0;
	int      out_cnt = 0;
	int      cyc = 0;

	mrd_reorder_top UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_data     (in_data),
		.frame_len   (frame_len),
		.out_valid   (out_valid),
		.out_data    (out_data),
		.out_last    (out_last),
		.busy        (busy),
		.sink_3_4    (sink_3_4),
		.timeout_err (timeout_err)
	);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at the first failure");
	endtask

	function automatic int three_quarter_point(input int len);
		return len / 4 + len / 2 - 1;
	endfunction

	// model: output k = b*R + a carries input a*7 + b
	task automatic send_frame(input int len);
		sample_t frame [$];
		int      rows;
		rows = len / NUM_BANKS;
		for (int n = 0; n < len; n++)
			frame.push_back(sample_t'($urandom));
		for (int b = 0; b < NUM_BANKS; b++) begin
			for (int a = 0; a < rows; a++) begin
				exp_q.push_back(frame[a * NUM_BANKS + b]);
				last_q.push_back(b == NUM_BANKS - 1 && a == rows - 1);
			end
		end
		cur_len = len;
		for (int n = 0; n < len; n++) begin
			@(posedge clk);
			in_valid  <= 1'b1;
			in_data   <= frame[n];
			frame_len <= LEN_W'(len);
		end
		@(posedge clk);
		in_valid <= 1'b0;
		in_data  <= '0;
	endtask

	task automatic wait_idle();
		do
			@(negedge clk);
		while (busy);
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0)
			@(negedge clk);
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_HALF) clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= MAX_CYCLES)
			report_failure($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
	end

	always @(negedge clk) begin
		sample_t exp_data;
		logic    exp_last;
		if (out_valid) begin
			if (exp_q.size() == 0) begin
				report_failure("an output sample appeared while no frame was pending");
			end else begin
				exp_data = exp_q.pop_front();
				exp_last = last_q.pop_front();
				assert (out_data == exp_data) else
					report_failure($sformatf("Error at %0d ns: output %0d is %h, expected %h",
						$time, out_cnt, out_data, exp_data));
				assert (out_last == exp_last) else
					report_failure($sformatf("Error at %0d ns: output %0d out_last %0b, expected %0b",
						$time, out_cnt, out_last, exp_last));
				out_cnt++;
			end
		end
	end

	// pulse due two cycles after the sample that reaches the mark is presented
	always @(negedge clk) begin
		logic due_now;
		if (in_valid)
			run_cnt++;
		else
			run_cnt = 0;
		due_now = in_valid && (run_cnt == three_quarter_point(cur_len));
		assert (sink_3_4 == due_d2) else
			report_failure($sformatf("Error at %0d ns: sink_3_4 is %0b, expected %0b",
				$time, sink_3_4, due_d2));
		due_d2 = due_d1;
		due_d1 = due_now;
	end

	always @(negedge clk) begin
		if (UUT.u_props.any_fail)
			report_failure("a bound property check on the top level failed");
	end

	initial begin
		void'($urandom(96));
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_data   = '0;
		frame_len = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (!out_valid && !out_last && !busy && !sink_3_4 && !timeout_err) else
			report_failure($sformatf("Error at %0d ns: outputs not idle after reset", $time));

		// single frames, drained one by one
		for (int i = 0; i < 3; i++) begin
			send_frame(FRAME_LENS[i]);
			wait_idle();
			wait_drained();
		end

		// back to back, each starting as soon as busy falls
		for (int i = 3; i < NUM_FRAMES; i++) begin
			send_frame(FRAME_LENS[i]);
			wait_idle();
		end
		wait_drained();

		// stall: valid held far past any legal frame
		cur_len = STALL_LEN;
		for (int n = 0; n < STALL_RUN; n++) begin
			@(posedge clk);
			in_valid  <= 1'b1;
			in_data   <= sample_t'($urandom);
			frame_len <= LEN_W'(STALL_LEN);
		end
		@(posedge clk);
		in_valid <= 1'b0;
		in_data  <= '0;
		repeat (10) @(negedge clk);
		assert (timeout_err && !busy) else
			report_failure($sformatf("Error at %0d ns: stall did not raise timeout_err", $time));
		repeat (10) @(negedge clk);
		assert (timeout_err) else
			report_failure($sformatf("Error at %0d ns: timeout_err cleared before reset", $time));

		@(posedge clk);
		rst_n <= 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (!timeout_err && !busy) else
			report_failure($sformatf("Error at %0d ns: reset did not clear timeout_err", $time));

		repeat (4) @(negedge clk);
		if (UUT.u_props.any_fail) begin
			$display("*** FAILED ***");
			$fatal(1, "property checker flagged a failure");
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verilog.f
common/mrd_cfg_pkg.sv
common/mrd_types_pkg.sv
logic/mrd_ctrl.sv
sink/mrd_sink.sv
logic/mrd_bank_array.sv
source/mrd_source.sv
logic/mrd_reorder_top.sv
tb/mrd_reorder_props.sv
tb/mrd_reorder_tb.sv

//--- Makefile
TB_TOP := mrd_reorder_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module mrd_reorder_top -f verilog.f
	verilator --lint-only --timing --assert --top-module $(TB_TOP) -f verilog.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TB_TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
